/* tb.f */
+incdir+testbench
verilog/mbus_pkg.sv
verilog/mbus_decode.sv
verilog/rom_mapper.sv
verilog/work_ram.sv
verilog/z80_ctrl.sv
verilog/mbus_arbiter.sv
verilog/mbus_system.sv
testbench/tb_mbus_system.sv

/* testbench/mbus_model.svh */
// Reference model of the bus controller state, included inside the testbench module.
// Needs mbus_pkg imported by the including module.
// RAM words read back only make sense after a full-word write.

`ifndef MBUS_MODEL_SVH
`define MBUS_MODEL_SVH

// Z80 control registers as word addresses
localparam mbus_addr_t BUSREQ_WORD = 23'h50_8880;
localparam mbus_addr_t RESET_WORD  = 23'h50_8900;

logic [15:0] ram_m [2**15];
logic [4:0]  bank_m [8];
logic        bank_mode_m;
logic [15:0] open_bus_m;
logic        busreq_m;
logic        run_m;

task automatic reset_model();
	open_bus_m  = 16'h4E71;
	bank_mode_m = 1'b0;
	busreq_m    = 1'b0;
	run_m       = 1'b0;
	for (int i = 0; i < 8; i++)
		bank_m[i] = 5'(i);
endtask

// Data word the ROM responder returns for a ROM word address
function automatic logic [15:0] rom_word(input logic [23:0] waddr);
	logic [15:0] prod;
	prod = waddr[15:0] * 16'h9E37;
	return prod ^ {waddr[23:16], waddr[22:15]} ^ 16'hC3A5;
endfunction

// Word address the ROM sees with 512 KB windows picked by byte bits 21:19
function automatic logic [23:0] translate_rom(input mbus_addr_t a);
	if (bank_mode_m)
		return {1'b0, bank_m[a[20:18]], a[17:0]};
	return {1'b0, a};
endfunction

function automatic logic [15:0] expected_read(input mbus_target_e tgt, input mbus_addr_t a,
		input logic busak_n);
	logic [15:0] w;
	case (tgt)
		TGT_RAM:      w = ram_m[a[14:0]];
		TGT_ROM:      w = rom_word(translate_rom(a));
		TGT_ROM_NONE: w = 16'h0000;
		TGT_CTRL: begin
			w = open_bus_m;
			// D8 carries the read-back bit
			w[8] = (a == RESET_WORD) ? run_m : busak_n;
		end
		default:      w = open_bus_m;
	endcase
	return w;
endfunction

task automatic update_after_cpu(input mbus_target_e tgt, input mbus_req_t cmd,
		input logic [15:0] rdata);
	logic [15:0] w;
	if (cmd.rnw) begin
		// Only RAM and ROM reads refresh the open-bus word
		if (tgt == TGT_RAM || tgt == TGT_ROM)
			open_bus_m = rdata;
	end else if (tgt == TGT_RAM) begin
		w = ram_m[cmd.addr[14:0]];
		if (cmd.be[1])
			w[15:8] = cmd.wdata[15:8];
		if (cmd.be[0])
			w[7:0] = cmd.wdata[7:0];
		ram_m[cmd.addr[14:0]] = w;
	end else if (tgt == TGT_BANK && cmd.addr[2:0] != 3'd0) begin
		bank_m[cmd.addr[2:0]] = cmd.wdata[4:0];
		bank_mode_m = 1'b1;
	end else if (tgt == TGT_CTRL && cmd.be[1]) begin
		if (cmd.addr == RESET_WORD)
			run_m = cmd.wdata[8];
		else
			busreq_m = cmd.wdata[8];
	end
endtask

`endif

/* testbench/tb_mbus_system.sv */
// Random testbench for the main bus controller with CPU and DMA masters running concurrently.
// A responder answers the ROM toggle handshake after 1 to 6 cycles.
// RAM traffic stays inside a small pool of words that are fully written first.

`timescale 1ns/1ps

module tb_mbus_system import mbus_pkg::*; ();

	localparam logic [31:0] SEED = 32'he1e6_7917;
	localparam int TIMEOUT   = 200;
	localparam int POOL_SIZE = 16;
	localparam int CPU_OPS   = 400;
	localparam int DMA_OPS   = 200;

	logic        MCLK;
	logic        reset;
	logic        cpu_req;
	mbus_req_t   cpu_cmd;
	logic        cpu_ack;
	logic [15:0] cpu_rdata;
	logic        dma_req;
	mbus_addr_t  dma_addr;
	logic        dma_ack;
	logic [15:0] dma_rdata;
	logic [23:0] rom_addr;
	logic        rom_req;
	logic        rom_ack;
	logic [15:0] rom_data;
	logic        z80_busak_n;
	logic        z80_busreq;
	logic        z80_run;
	int          errors;
	int          checks;
	bit          timed_out;
	logic [14:0] ram_pool [POOL_SIZE];

	`include "mbus_model.svh"

	mbus_system #(
		.ROM_SIZE (32'h0040_0000)
	) i_mbus_system (
		.MCLK        (MCLK),
		.reset       (reset),
		.cpu_req     (cpu_req),
		.cpu_cmd     (cpu_cmd),
		.cpu_ack     (cpu_ack),
		.cpu_rdata   (cpu_rdata),
		.dma_req     (dma_req),
		.dma_addr    (dma_addr),
		.dma_ack     (dma_ack),
		.dma_rdata   (dma_rdata),
		.rom_addr    (rom_addr),
		.rom_req     (rom_req),
		.rom_ack     (rom_ack),
		.rom_data    (rom_data),
		.z80_busak_n (z80_busak_n),
		.z80_busreq  (z80_busreq),
		.z80_run     (z80_run)
	);

	always #4 MCLK = ~MCLK;

	// ------------------------------------------------------------------------
	// Checking and run control
	// ------------------------------------------------------------------------

	task automatic compare_value(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at time %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic finish_run();
		$display("errors: %0d, checks: %0d", errors, checks);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	endtask

	// Wait on negedges until the chosen ack reaches the level
	task automatic wait_ack(input bit dma, input logic level);
		int n;
		n = 0;
		while ((dma ? dma_ack : cpu_ack) !== level && n < TIMEOUT) begin
			@(negedge MCLK);
			n++;
		end
		if ((dma ? dma_ack : cpu_ack) !== level) begin
			errors++;
			timed_out = 1'b1;
			$display("At time %0t the %s ack did not %s within %0d cycles", $time,
				dma ? "DMA" : "CPU", level ? "rise" : "drop", TIMEOUT);
		end
	endtask

	// ------------------------------------------------------------------------
	// Masters
	// ------------------------------------------------------------------------

	function automatic mbus_req_t make_cmd(input mbus_addr_t a, input logic [15:0] d,
			input logic rnw, input logic [1:0] be);
		mbus_req_t c;
		c.addr  = a;
		c.wdata = d;
		c.rnw   = rnw;
		c.be    = be;
		return c;
	endfunction

	// Weighted address classes that keep DMA away from control and bank registers
	task automatic pick_address(input bit dma, output mbus_target_e tgt, output mbus_addr_t a);
		int          w;
		logic [4:0]  mirror;
		logic [19:0] low;
		w      = $urandom_range(99);
		mirror = 5'($urandom);
		low    = 20'($urandom);
		if (w < 35) begin
			tgt = TGT_RAM;
			a   = {3'b111, mirror, ram_pool[$urandom_range(POOL_SIZE - 1)]};
		end else if (w < 60) begin
			tgt = TGT_ROM;
			a   = 23'($urandom_range(23'h1F_FFFF));
		end else if (w < 68) begin
			tgt = TGT_ROM_NONE;
			a   = 23'($urandom_range(23'h4F_FFFF, 23'h20_0000));
		end else if (w < 80 || dma) begin
			tgt = TGT_OPEN;
			a   = {3'b110, low};
		end else if (w < 90) begin
			tgt = TGT_CTRL;
			a   = low[0] ? RESET_WORD : BUSREQ_WORD;
		end else begin
			tgt = TGT_BANK;
			a   = {16'hA130, low[6:0]};
		end
	endtask

	// Called on a falling edge and returns on one
	task automatic cpu_transfer(input mbus_target_e tgt, input mbus_req_t cmd);
		logic [15:0] exp;
		exp = 16'h0000;
		if (!timed_out) begin
			cpu_cmd = cmd;
			cpu_req = 1'b1;
			wait_ack(1'b0, 1'b1);
		end
		if (!timed_out) begin
			if (cmd.rnw) begin
				exp = expected_read(tgt, cmd.addr, z80_busak_n);
				compare_value("cpu_rdata", cpu_rdata, exp);
			end
			update_after_cpu(tgt, cmd, exp);
			compare_value("z80_busreq", {15'd0, z80_busreq}, {15'd0, busreq_m});
			compare_value("z80_run", {15'd0, z80_run}, {15'd0, run_m});
			cpu_req = 1'b0;
			wait_ack(1'b0, 1'b0);
		end
	endtask

	task automatic dma_transfer(input mbus_target_e tgt, input mbus_addr_t a);
		if (!timed_out) begin
			dma_addr = a;
			dma_req  = 1'b1;
			wait_ack(1'b1, 1'b1);
		end
		if (!timed_out) begin
			compare_value("dma_rdata", dma_rdata, expected_read(tgt, a, z80_busak_n));
			dma_req = 1'b0;
			wait_ack(1'b1, 1'b0);
		end
	endtask

	task automatic cpu_master();
		mbus_target_e tgt;
		mbus_addr_t   a;
		logic         rnw;
		for (int i = 0; i < CPU_OPS && !timed_out; i++) begin
			repeat ($urandom_range(3)) @(negedge MCLK);
			// BUSACK only moves while the CPU is between accesses
			if ($urandom_range(3) == 0)
				z80_busak_n = ~z80_busak_n;
			pick_address(1'b0, tgt, a);
			rnw = (tgt == TGT_ROM) ? ($urandom_range(3) != 0) : ($urandom_range(1) != 0);
			cpu_transfer(tgt, make_cmd(a, 16'($urandom), rnw, 2'($urandom)));
		end
	endtask

	task automatic dma_master();
		mbus_target_e tgt;
		mbus_addr_t   a;
		for (int i = 0; i < DMA_OPS && !timed_out; i++) begin
			repeat ($urandom_range(3)) @(negedge MCLK);
			pick_address(1'b1, tgt, a);
			dma_transfer(tgt, a);
		end
	endtask

	// ROM responder answering each toggle of rom_req
	initial begin
		int d;
		forever begin
			@(negedge MCLK);
			if (reset === 1'b0 && rom_req !== rom_ack) begin
				d = $urandom_range(6, 1);
				repeat (d - 1) @(negedge MCLK);
				rom_data = rom_word(rom_addr);
				rom_ack  = rom_req;
			end
		end
	end

	// Only one access may be acknowledged at a time
	always @(negedge MCLK) begin
		if (reset === 1'b0)
			compare_value("cpu_ack & dma_ack", {15'd0, cpu_ack & dma_ack}, 16'h0000);
	end

	initial begin
		int unsigned seed;
		int          n;
		seed = SEED;
		void'($urandom(seed));
		MCLK        = 1'b0;
		reset       = 1'b1;
		cpu_req     = 1'b0;
		cpu_cmd     = '0;
		dma_req     = 1'b0;
		dma_addr    = '0;
		rom_ack     = 1'b0;
		rom_data    = 16'h0000;
		z80_busak_n = 1'b1;
		errors      = 0;
		checks      = 0;
		timed_out   = 1'b0;
		reset_model();
		for (int k = 0; k < POOL_SIZE; k++)
			ram_pool[k] = 15'($urandom);
		repeat (10) @(posedge MCLK);
		@(negedge MCLK);
		reset = 1'b0;

		compare_value("cpu_ack", {15'd0, cpu_ack}, 16'h0000);
		compare_value("dma_ack", {15'd0, dma_ack}, 16'h0000);
		compare_value("rom_req", {15'd0, rom_req}, 16'h0000);
		compare_value("z80_busreq", {15'd0, z80_busreq}, 16'h0000);
		compare_value("z80_run", {15'd0, z80_run}, 16'h0000);

		// Open bus after reset is not disturbed by a DMA read
		cpu_transfer(TGT_OPEN, make_cmd({3'b110, 20'h1_2345}, 16'h0000, 1'b1, 2'b11));
		dma_transfer(TGT_ROM, 23'h00_1234);
		cpu_transfer(TGT_BANK, make_cmd({16'hA130, 7'h05}, 16'h0000, 1'b1, 2'b11));

		// Fill the pool and read back through another mirror from both masters
		for (int k = 0; k < POOL_SIZE; k++)
			cpu_transfer(TGT_RAM, make_cmd({8'hFF, ram_pool[k]}, 16'($urandom), 1'b0, 2'b11));
		cpu_transfer(TGT_RAM, make_cmd({8'hE0, ram_pool[0]}, 16'h0000, 1'b1, 2'b11));
		dma_transfer(TGT_RAM, {8'hF8, ram_pool[0]});

		// Unbanked ROM read followed by a bank register write and a read in its window
		cpu_transfer(TGT_ROM, make_cmd(23'h1A_2B3C, 16'h0000, 1'b1, 2'b11));
		n = $urandom_range(7, 1);
		cpu_transfer(TGT_BANK, make_cmd({16'hA130, 4'h0, n[2:0]}, 16'($urandom), 1'b0, 2'b11));
		cpu_transfer(TGT_ROM, make_cmd({2'b00, n[2:0], 18'h0_4567}, 16'h0000, 1'b1, 2'b11));

		fork
			cpu_master();
			dma_master();
		join
		finish_run();
	end

endmodule

/* verilog/mbus_arbiter.sv */
// Bus arbiter and access sequencer, one access in flight at a time.
// CPU wins over DMA when both request in idle. DMA accesses are always reads.
// Writes to ROM space are acknowledged without a ROM cycle.
// Only CPU reads of RAM or ROM refresh the open-bus word.

`timescale 1ns/1ps

module mbus_arbiter import mbus_pkg::*; (
	input  logic         MCLK,
	input  logic         reset,

	input  logic         cpu_req,
	input  mbus_req_t    cpu_cmd,
	output logic         cpu_ack,
	output logic [15:0]  cpu_rdata,

	input  logic         dma_req,
	input  mbus_addr_t   dma_addr,
	output logic         dma_ack,
	output logic [15:0]  dma_rdata,

	output logic         rom_req,
	input  logic         rom_ack,
	input  logic [15:0]  rom_data,

	output mbus_addr_t   bus_addr,
	output logic [15:0]  bus_wdata,
	output logic [1:0]   bus_be,
	input  mbus_target_e target,
	output logic         bank_we,
	output logic         ram_we,
	input  logic [15:0]  ram_rdata,
	output logic         ctrl_we,
	input  logic         ctrl_bit
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_SELECT,
		S_RAM,
		S_ROM,
		S_ACK
	} state_e;

	state_e      state;
	mbus_req_t   bus;
	logic        src_dma;
	logic [15:0] open_bus;
	logic [15:0] rd_data;
	logic [15:0] imm_data;
	logic        start;
	logic        wr_slot;
	logic        req_held;

	assign start   = (state == S_IDLE) && (cpu_req || dma_req);
	assign wr_slot = (state == S_SELECT) && !bus.rnw;

	// Request of the master currently owning the bus
	assign req_held = src_dma ? dma_req : cpu_req;

	// ------------------------------------------------------------------------
	// Command capture
	// ------------------------------------------------------------------------

	always_ff @(posedge MCLK) begin
		if (start) begin
			if (cpu_req) begin
				bus <= cpu_cmd;
			end else begin
				bus.addr  <= dma_addr;
				bus.wdata <= '0;
				bus.rnw   <= 1'b1;
				bus.be    <= 2'b11;
			end
		end
	end

	assign bus_addr  = bus.addr;
	assign bus_wdata = bus.wdata;
	assign bus_be    = bus.be;

	// Write strobes, one cycle in SELECT
	assign ram_we  = wr_slot && (target == TGT_RAM);
	assign bank_we = wr_slot && (target == TGT_BANK);
	assign ctrl_we = wr_slot && (target == TGT_CTRL);

	// Data for targets that answer without waiting
	always_comb begin
		case (target)
			TGT_ROM_NONE: imm_data = '0;
			TGT_CTRL:     imm_data = {open_bus[15:9], ctrl_bit, open_bus[7:0]};
			default:      imm_data = open_bus;
		endcase
	end

	// ------------------------------------------------------------------------
	// Sequencer
	// ------------------------------------------------------------------------

	always_ff @(posedge MCLK) begin
		if (reset) begin
			state    <= S_IDLE;
			src_dma  <= 1'b0;
			rom_req  <= 1'b0;
			open_bus <= OPEN_BUS_INIT;
		end else begin
			case (state)
				S_IDLE: begin
					if (start) begin
						src_dma <= !cpu_req;
						state   <= S_SELECT;
					end
				end

				S_SELECT: begin
					if (bus.rnw && target == TGT_RAM) begin
						state <= S_RAM;
					end else if (bus.rnw && target == TGT_ROM) begin
						// Start a ROM cycle by making req differ from ack
						rom_req <= ~rom_ack;
						state   <= S_ROM;
					end else begin
						rd_data <= imm_data;
						state   <= S_ACK;
					end
				end

				// RAM read data arrives one cycle after SELECT
				S_RAM: begin
					rd_data <= ram_rdata;
					if (!src_dma)
						open_bus <= ram_rdata;
					state <= S_ACK;
				end

				S_ROM: begin
					if (rom_req == rom_ack) begin
						rd_data <= rom_data;
						if (!src_dma)
							open_bus <= rom_data;
						state <= S_ACK;
					end
				end

				// Hold ack until the owner drops its request
				S_ACK: begin
					if (!req_held)
						state <= S_IDLE;
				end

				default: state <= S_IDLE;
			endcase
		end
	end

	assign cpu_ack   = (state == S_ACK) && !src_dma;
	assign dma_ack   = (state == S_ACK) && src_dma;
	assign cpu_rdata = rd_data;
	assign dma_rdata = rd_data;

endmodule

/* verilog/mbus_decode.sv */
// Address decoder for the 68000 memory map, purely combinational.
// ROM space ends at 400000 or at ROM_SIZE, whichever comes first.
// Only the exact Z80 control addresses decode, no mirrors.

`timescale 1ns/1ps

module mbus_decode import mbus_pkg::*; #(
	parameter int unsigned ROM_SIZE = 32'h0040_0000
) (
	input  mbus_addr_t   bus_addr,
	output mbus_target_e target
);

	logic [23:0] byte_addr;

	assign byte_addr = {bus_addr, 1'b0};

	always_comb begin
		// Cartridge space
		if (byte_addr < ROM_WINDOW_END && 32'(byte_addr) < ROM_SIZE) begin
			target = TGT_ROM;
		end else if (byte_addr < CART_SPACE_END) begin
			target = TGT_ROM_NONE;

		// Z80 bus request and reset
		end else if (byte_addr == Z80_BUSREQ_ADDR || byte_addr == Z80_RESET_ADDR) begin
			target = TGT_CTRL;

		// Mapper registers A13000-A130FF
		end else if (byte_addr[23:8] == BANK_PAGE) begin
			target = TGT_BANK;

		// Work RAM mirrors E00000-FFFFFF
		end else if (byte_addr[23:21] == RAM_SEGMENT) begin
			target = TGT_RAM;
		end else begin
			target = TGT_OPEN;
		end
	end

endmodule

/* verilog/mbus_pkg.sv */
// Shared types and memory map for the 68000-side bus controller.
// Addresses on the internal bus are word addresses (byte address bits 23:1).
// Byte enables are active high, bit 1 is the upper byte (D15..D8).

package mbus_pkg;

	// ------------------------------------------------------------------------
	// Bus types
	// ------------------------------------------------------------------------

	// Word address, byte address bits 23 down to 1
	typedef logic [22:0] mbus_addr_t;

	// One bus command as issued by a master
	typedef struct packed {
		mbus_addr_t  addr;
		logic [15:0] wdata;
		logic        rnw;
		logic [1:0]  be;
	} mbus_req_t;

	// Decoded target of the current bus address
	typedef enum logic [2:0] {
		TGT_ROM,
		TGT_ROM_NONE,
		TGT_RAM,
		TGT_BANK,
		TGT_CTRL,
		TGT_OPEN
	} mbus_target_e;

	// ------------------------------------------------------------------------
	// Constants
	// ------------------------------------------------------------------------

	// NOP opcode, what an idle 68000 bus floats to after power-up
	localparam logic [15:0] OPEN_BUS_INIT = 16'h4E71;

	// SSF2 style mapper, eight 512 KB windows
	localparam int BANK_BITS  = 5;
	localparam int BANK_COUNT = 8;

	// 64 KB work RAM as 32K words
	localparam int RAM_ADDR_W = 15;

	// Byte address map
	localparam logic [23:0] ROM_WINDOW_END  = 24'h40_0000;
	localparam logic [23:0] CART_SPACE_END  = 24'hA0_0000;
	localparam logic [23:0] Z80_BUSREQ_ADDR = 24'hA1_1100;
	localparam logic [23:0] Z80_RESET_ADDR  = 24'hA1_1200;
	localparam logic [15:0] BANK_PAGE       = 16'hA130;
	localparam logic [2:0]  RAM_SEGMENT     = 3'b111;

endpackage

/* verilog/mbus_system.sv */
// Main bus controller top level.
// CPU and DMA masters use a four-phase req/ack, the ROM a toggle handshake.
// ROM_SIZE is in bytes and only bounds the decoded ROM space.

`timescale 1ns/1ps

module mbus_system import mbus_pkg::*; #(
	parameter int unsigned ROM_SIZE = 32'h0040_0000
) (
	input  logic        MCLK,
	input  logic        reset,

	input  logic        cpu_req,
	input  mbus_req_t   cpu_cmd,
	output logic        cpu_ack,
	output logic [15:0] cpu_rdata,

	input  logic        dma_req,
	input  mbus_addr_t  dma_addr,
	output logic        dma_ack,
	output logic [15:0] dma_rdata,

	output logic [23:0] rom_addr,
	output logic        rom_req,
	input  logic        rom_ack,
	input  logic [15:0] rom_data,

	input  logic        z80_busak_n,
	output logic        z80_busreq,
	output logic        z80_run
);

	mbus_addr_t   bus_addr;
	logic [15:0]  bus_wdata;
	logic [1:0]   bus_be;
	mbus_target_e target;
	logic         bank_we;
	logic         ram_we;
	logic [15:0]  ram_rdata;
	logic         ctrl_we;
	logic         ctrl_bit;

	mbus_arbiter i_mbus_arbiter (
		.MCLK       (MCLK),
		.reset      (reset),
		.cpu_req    (cpu_req),
		.cpu_cmd    (cpu_cmd),
		.cpu_ack    (cpu_ack),
		.cpu_rdata  (cpu_rdata),
		.dma_req    (dma_req),
		.dma_addr   (dma_addr),
		.dma_ack    (dma_ack),
		.dma_rdata  (dma_rdata),
		.rom_req    (rom_req),
		.rom_ack    (rom_ack),
		.rom_data   (rom_data),
		.bus_addr   (bus_addr),
		.bus_wdata  (bus_wdata),
		.bus_be     (bus_be),
		.target     (target),
		.bank_we    (bank_we),
		.ram_we     (ram_we),
		.ram_rdata  (ram_rdata),
		.ctrl_we    (ctrl_we),
		.ctrl_bit   (ctrl_bit)
	);

	mbus_decode #(
		.ROM_SIZE (ROM_SIZE)
	) i_mbus_decode (
		.bus_addr (bus_addr),
		.target   (target)
	);

	rom_mapper i_rom_mapper (
		.MCLK      (MCLK),
		.reset     (reset),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.bank_we   (bank_we),
		.rom_addr  (rom_addr)
	);

	// 64 KB mirrored across E00000-FFFFFF
	work_ram i_work_ram (
		.MCLK  (MCLK),
		.addr  (bus_addr[RAM_ADDR_W-1:0]),
		.wdata (bus_wdata),
		.be    (bus_be),
		.we    (ram_we),
		.rdata (ram_rdata)
	);

	z80_ctrl i_z80_ctrl (
		.MCLK        (MCLK),
		.reset       (reset),
		.bus_addr    (bus_addr),
		.bus_wdata   (bus_wdata),
		.bus_be      (bus_be),
		.ctrl_we     (ctrl_we),
		.z80_busak_n (z80_busak_n),
		.z80_busreq  (z80_busreq),
		.z80_run     (z80_run),
		.ctrl_bit    (ctrl_bit)
	);

endmodule

/* verilog/rom_mapper.sv */
// SSF2 style ROM bank mapper with eight 512 KB windows.
// Register 0 is fixed, a write to it is ignored.
// Banking turns on with the first write to registers 1 to 7 and stays on.

`timescale 1ns/1ps

module rom_mapper import mbus_pkg::*; (
	input  logic        MCLK,
	input  logic        reset,
	input  mbus_addr_t  bus_addr,
	input  logic [15:0] bus_wdata,
	input  logic        bank_we,
	output logic [23:0] rom_addr
);

	logic [BANK_BITS-1:0] bank_reg [BANK_COUNT];
	logic                 bank_mode;
	logic [2:0]           wr_sel;
	logic [2:0]           win_sel;

	// Register select from byte address bits 3:1
	assign wr_sel = bus_addr[2:0];

	// Window select from byte address bits 21:19
	assign win_sel = bus_addr[20:18];

	always_ff @(posedge MCLK) begin
		if (reset) begin
			bank_mode <= 1'b0;
			for (int i = 0; i < BANK_COUNT; i++)
				bank_reg[i] <= BANK_BITS'(i);
		end else if (bank_we && wr_sel != 3'd0) begin
			bank_reg[wr_sel] <= bus_wdata[BANK_BITS-1:0];
			bank_mode        <= 1'b1;
		end
	end

	// Word address out, top bit unused by this map
	always_comb begin
		if (bank_mode)
			rom_addr = {1'b0, bank_reg[win_sel], bus_addr[17:0]};
		else
			rom_addr = {1'b0, bus_addr};
	end

endmodule

/* verilog/work_ram.sv */
// 32K x 16 work RAM, single port.
// Registered read, data one cycle after the address.
// No power-up clear, contents are undefined until written.

`timescale 1ns/1ps

module work_ram import mbus_pkg::*; (
	input  logic                  MCLK,
	input  logic [RAM_ADDR_W-1:0] addr,
	input  logic [15:0]           wdata,
	input  logic [1:0]            be,
	input  logic                  we,
	output logic [15:0]           rdata
);

	logic [1:0][7:0] mem [2**RAM_ADDR_W];

	always_ff @(posedge MCLK) begin
		// Upper lane
		if (we && be[1])
			mem[addr][1] <= wdata[15:8];
		// Lower lane
		if (we && be[0])
			mem[addr][0] <= wdata[7:0];
		rdata <= mem[addr];
	end

endmodule

/* verilog/z80_ctrl.sv */
// Z80 bus request (A11100) and reset release (A11200) registers.
// Only writes with the upper byte lane enabled have any effect.
// z80_run low holds the Z80 in reset.

`timescale 1ns/1ps

module z80_ctrl import mbus_pkg::*; (
	input  logic        MCLK,
	input  logic        reset,
	input  mbus_addr_t  bus_addr,
	input  logic [15:0] bus_wdata,
	input  logic [1:0]  bus_be,
	input  logic        ctrl_we,
	input  logic        z80_busak_n,
	output logic        z80_busreq,
	output logic        z80_run,
	output logic        ctrl_bit
);

	logic reset_reg_sel;

	// Byte address bit 9 tells A11200 from A11100
	assign reset_reg_sel = bus_addr[8];

	always_ff @(posedge MCLK) begin
		if (reset) begin
			z80_busreq <= 1'b0;
			z80_run    <= 1'b0;
		end else if (ctrl_we && bus_be[1]) begin
			if (reset_reg_sel)
				z80_run <= bus_wdata[8];
			else
				z80_busreq <= bus_wdata[8];
		end
	end

	// Read-back bit, lands on D8 of the open-bus word
	assign ctrl_bit = reset_reg_sel ? z80_run : z80_busak_n;

endmodule
